// File: verilog/probe_pkg.sv
// probe widths, register map, mode enum and vector typedefs
`default_nettype none

package probe_pkg;

   // stream geometry
   localparam int data_bytes   = 8;   // tkeep lanes
   localparam int beat_bytes_w = 4;   // up to data_bytes in one beat
   localparam int pkt_bytes_w  = 16;  // intermediate per-packet sum

   // counter and register widths
   localparam int pkt_cnt_w  = 50;
   localparam int byte_cnt_w = 56;
   localparam int reg_addr_w = 3;
   localparam int reg_data_w = 32;
   localparam int mode_w     = 2;

   typedef logic [data_bytes-1:0]   keep_t;
   typedef logic [beat_bytes_w-1:0] beat_bytes_t;
   typedef logic [pkt_bytes_w-1:0]  pkt_bytes_t;
   typedef logic [pkt_cnt_w-1:0]    pkt_cnt_t;
   typedef logic [byte_cnt_w-1:0]   byte_cnt_t;
   typedef logic [reg_addr_w-1:0]   reg_addr_t;
   typedef logic [reg_data_w-1:0]   reg_data_t;

   // what the probe counts
   typedef enum logic [mode_w-1:0] {
      mode_good   = 2'd0,  // accepted beats, error-free packets
      mode_ovfl   = 2'd1,  // beats offered with tready low
      mode_errors = 2'd2,  // accepted beats, flagged packets
      mode_off    = 2'd3
   } probe_mode_t;

   // register map
   localparam reg_addr_t addr_control  = 3'd0;
   localparam reg_addr_t addr_pkt_lo   = 3'd1;
   localparam reg_addr_t addr_pkt_hi   = 3'd2;
   localparam reg_addr_t addr_byte_lo  = 3'd3;
   localparam reg_addr_t addr_byte_hi  = 3'd4;

   // control register fields
   localparam int ctrl_clear_bit = 0;  // write event, reads back 0
   localparam int ctrl_latch_bit = 1;
   localparam int ctrl_mode_lsb  = 2;  // bits 3:2

endpackage

`default_nettype wire

// File: verilog/beat_if.sv
// beat_if interface with src and dst modports for one qualified stream beat
`default_nettype none

interface beat_if;
   import probe_pkg::*;

   logic  hit;   // beat counts under current mode
   keep_t keep;  // byte lanes of the beat
   logic  last;  // end of packet
   logic  err;   // packet error flag, valid with last

   // producer side, valid-only
   modport src (
      output hit,
      output keep,
      output last,
      output err
   );

   // consumer side, always ready
   modport dst (
      input hit,
      input keep,
      input last,
      input err
   );

endinterface

`default_nettype wire

// File: verilog/beat_capture.sv
// beat_capture module, registers the stream signals and qualifies each beat by mode
`default_nettype none

module beat_capture (
   input  logic                  axi4s_if,
   input  logic                  arst_n,
   input  logic                  tvalid,
   input  logic                  tready,
   input  logic                  tlast,
   input  logic                  tuser,
   input  probe_pkg::keep_t      tkeep,
   input  probe_pkg::probe_mode_t mode,
   beat_if.src                   beat
);
   import probe_pkg::*;

   logic qual;

   // stream qualifier per mode
   always_comb begin
      case (mode)
         mode_good,
         mode_errors: qual = tvalid && tready;
         mode_ovfl:   qual = tvalid && !tready;  // sink not taking the beat
         default:     qual = 1'b0;
      endcase
   end

   always_ff @(posedge axi4s_if or negedge arst_n) begin
      if (!arst_n) begin
         beat.hit  <= 1'b0;
         beat.last <= 1'b0;
         beat.err  <= 1'b0;
      end else begin
         beat.hit  <= qual;
         beat.last <= tlast;
         beat.err  <= tlast && tuser;  // error flag only means something on tlast
      end
   end

   // lanes only matter when hit is set
   always_ff @(posedge axi4s_if) begin
      beat.keep <= tkeep;
   end

endmodule

`default_nettype wire

// File: verilog/byte_tally.sv
// byte_tally module, per-packet byte sum from tkeep with a packet-done strobe
`default_nettype none

module byte_tally (
   input  logic                  axi4s_if,
   input  logic                  arst_n,
   beat_if.dst                   beat,
   output logic                  pkt_done,
   output logic                  pkt_err,
   output probe_pkg::pkt_bytes_t pkt_bytes
);
   import probe_pkg::*;

   // number of valid lanes in one beat
   function automatic beat_bytes_t count_ones(input keep_t k);
      beat_bytes_t n;
      n = '0;
      for (int i = 0; i < data_bytes; i++) begin
         n = n + beat_bytes_t'(k[i]);
      end
      return n;
   endfunction

   beat_bytes_t beat_ones;
   pkt_bytes_t  run_sum;   // bytes of the packet so far
   pkt_bytes_t  sum_next;

   assign beat_ones = count_ones(beat.keep);
   assign sum_next  = run_sum + pkt_bytes_t'(beat_ones);

   always_ff @(posedge axi4s_if or negedge arst_n) begin
      if (!arst_n) begin
         run_sum   <= '0;
         pkt_done  <= 1'b0;
         pkt_err   <= 1'b0;
         pkt_bytes <= '0;
      end else begin
         pkt_done <= beat.hit && beat.last;
         if (beat.hit) begin
            if (beat.last) begin
               pkt_bytes <= sum_next;  // total including the last beat
               pkt_err   <= beat.err;
               run_sum   <= '0;        // next packet starts clean
            end else begin
               run_sum   <= sum_next;
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: verilog/probe_counters.sv
// probe_counters module, packet and byte counters with mode filter and clear
`default_nettype none

module probe_counters (
   input  logic                   axi4s_if,
   input  logic                   arst_n,
   input  logic                   pkt_done,
   input  logic                   pkt_err,
   input  logic                   clear_evt,
   input  probe_pkg::pkt_bytes_t  pkt_bytes,
   input  probe_pkg::probe_mode_t mode,
   output probe_pkg::pkt_cnt_t    pkt_cnt,
   output probe_pkg::byte_cnt_t   byte_cnt
);
   import probe_pkg::*;

   logic drop;
   logic incr;

   // packet filter by error flag
   always_comb begin
      case (mode)
         mode_good:   drop = pkt_err;   // good mode skips flagged packets
         mode_errors: drop = !pkt_err;  // only flagged packets count
         default:     drop = 1'b0;      // ovfl takes every packet
      endcase
   end

   assign incr = pkt_done && !drop;

   // clear wins, a packet finishing in that cycle is lost
   always_ff @(posedge axi4s_if or negedge arst_n) begin
      if (!arst_n) begin
         pkt_cnt  <= '0;
         byte_cnt <= '0;
      end else if (clear_evt) begin
         pkt_cnt  <= '0;
         byte_cnt <= '0;
      end else if (incr) begin
         pkt_cnt  <= pkt_cnt + pkt_cnt_t'(1);
         byte_cnt <= byte_cnt + byte_cnt_t'(pkt_bytes);
      end
   end

endmodule

`default_nettype wire

// File: verilog/probe_regs.sv
// probe_regs module, control register, counter snapshot and read mux
`default_nettype none

module probe_regs (
   input  logic                   axi4s_if,
   input  logic                   arst_n,
   input  logic                   reg_wr,
   input  probe_pkg::reg_addr_t   reg_addr,
   input  probe_pkg::reg_data_t   reg_wdata,
   input  probe_pkg::pkt_cnt_t    pkt_cnt,
   input  probe_pkg::byte_cnt_t   byte_cnt,
   output probe_pkg::reg_data_t   reg_rdata,
   output probe_pkg::probe_mode_t mode,
   output logic                   clear_evt
);
   import probe_pkg::*;

   logic      ctrl_wr;    // write strobe to the control register
   logic      latch;      // 1 = snapshot only on control writes
   logic      snap_en;
   pkt_cnt_t  pkt_snap;
   byte_cnt_t byte_snap;

   assign ctrl_wr   = reg_wr && (reg_addr == addr_control);
   assign clear_evt = ctrl_wr && reg_wdata[ctrl_clear_bit];

   // control fields
   always_ff @(posedge axi4s_if or negedge arst_n) begin
      if (!arst_n) begin
         mode  <= mode_good;
         latch <= 1'b0;
      end else if (ctrl_wr) begin
         mode  <= probe_mode_t'(reg_wdata[ctrl_mode_lsb +: mode_w]);
         latch <= reg_wdata[ctrl_latch_bit];
      end
   end

   // free-running copy, or held until the next control write
   assign snap_en = ctrl_wr || !latch;

   always_ff @(posedge axi4s_if or negedge arst_n) begin
      if (!arst_n) begin
         pkt_snap  <= '0;
         byte_snap <= '0;
      end else if (snap_en) begin
         pkt_snap  <= pkt_cnt;
         byte_snap <= byte_cnt;
      end
   end

   // read mux
   always_comb begin
      case (reg_addr)
         addr_control: begin
            reg_rdata = '0;
            reg_rdata[ctrl_mode_lsb +: mode_w] = mode;
            reg_rdata[ctrl_latch_bit]          = latch;
         end
         addr_pkt_lo:  reg_rdata = pkt_snap[reg_data_w-1:0];
         addr_pkt_hi:  reg_rdata = reg_data_t'(pkt_snap[pkt_cnt_w-1:reg_data_w]);    // 18 bits
         addr_byte_lo: reg_rdata = byte_snap[reg_data_w-1:0];
         addr_byte_hi: reg_rdata = reg_data_t'(byte_snap[byte_cnt_w-1:reg_data_w]);  // 24 bits
         default:      reg_rdata = '0;
      endcase
   end

endmodule

`default_nettype wire

// File: verilog/axi4s_probe_top.sv
// axi4s_probe_top module, chains capture, tally, counters and register stages
`default_nettype none

module axi4s_probe_top (
   input  logic                 axi4s_if,
   input  logic                 arst_n,
   input  logic                 tvalid,
   input  logic                 tready,
   input  logic                 tlast,
   input  logic                 tuser,
   input  probe_pkg::keep_t     tkeep,
   input  logic                 reg_wr,
   input  probe_pkg::reg_addr_t reg_addr,
   input  probe_pkg::reg_data_t reg_wdata,
   output probe_pkg::reg_data_t reg_rdata
);
   import probe_pkg::*;

   probe_mode_t mode;
   logic        clear_evt;
   logic        pkt_done;
   logic        pkt_err;
   pkt_bytes_t  pkt_bytes;
   pkt_cnt_t    pkt_cnt;
   byte_cnt_t   byte_cnt;

   beat_if beat ();  // stage 1 to stage 2

   beat_capture u_capture (
      .axi4s_if (axi4s_if),
      .arst_n   (arst_n),
      .tvalid   (tvalid),
      .tready   (tready),
      .tlast    (tlast),
      .tuser    (tuser),
      .tkeep    (tkeep),
      .mode     (mode),
      .beat     (beat.src)
   );

   byte_tally u_tally (
      .axi4s_if  (axi4s_if),
      .arst_n    (arst_n),
      .beat      (beat.dst),
      .pkt_done  (pkt_done),
      .pkt_err   (pkt_err),
      .pkt_bytes (pkt_bytes)
   );

   probe_counters u_counters (
      .axi4s_if  (axi4s_if),
      .arst_n    (arst_n),
      .pkt_done  (pkt_done),
      .pkt_err   (pkt_err),
      .clear_evt (clear_evt),
      .pkt_bytes (pkt_bytes),
      .mode      (mode),
      .pkt_cnt   (pkt_cnt),
      .byte_cnt  (byte_cnt)
   );

   probe_regs u_regs (
      .axi4s_if  (axi4s_if),
      .arst_n    (arst_n),
      .reg_wr    (reg_wr),
      .reg_addr  (reg_addr),
      .reg_wdata (reg_wdata),
      .pkt_cnt   (pkt_cnt),
      .byte_cnt  (byte_cnt),
      .reg_rdata (reg_rdata),
      .mode      (mode),
      .clear_evt (clear_evt)
   );

endmodule

`default_nettype wire

// File: test/probe_tb_sva.sv
// probe_tb_sva assertion module and its bind into axi4s_probe_top
`default_nettype none

module probe_tb_sva (
   input logic                 axi4s_if,
   input logic                 arst_n,
   input logic                 hit,
   input logic                 last,
   input logic                 pkt_done,
   input logic                 clear_evt,
   input probe_pkg::pkt_bytes_t pkt_bytes,
   input probe_pkg::pkt_cnt_t   pkt_cnt,
   input probe_pkg::byte_cnt_t  byte_cnt
);
   import probe_pkg::*;

   int beats_open;  // hit beats of the packet in progress
   int pkt_len;     // hit beats of the packet just closed

   always_ff @(posedge axi4s_if or negedge arst_n) begin
      if (!arst_n) begin
         beats_open <= 0;
         pkt_len    <= 0;
      end else if (hit) begin
         if (last) begin
            pkt_len    <= beats_open + 1;
            beats_open <= 0;
         end else begin
            beats_open <= beats_open + 1;
         end
      end
   end

   no_done_after_reset: assert property (@(posedge axi4s_if) $rose(arst_n) |-> !pkt_done)
      else $error("pkt_done high in the first cycle after reset");

   // counts only move down through a clear
   pkt_cnt_no_drop: assert property (@(posedge axi4s_if) disable iff (!arst_n)
      !$past(clear_evt) |-> pkt_cnt >= $past(pkt_cnt))
      else $error("packet counter decreased without a clear");

   byte_cnt_no_drop: assert property (@(posedge axi4s_if) disable iff (!arst_n)
      !$past(clear_evt) |-> byte_cnt >= $past(byte_cnt))
      else $error("byte counter decreased without a clear");

   pkt_bytes_bound: assert property (@(posedge axi4s_if) disable iff (!arst_n)
      pkt_done |-> int'(pkt_bytes) <= pkt_len * data_bytes)
      else $error("packet byte sum larger than its beats can carry");

endmodule

bind axi4s_probe_top probe_tb_sva u_sva (
   .axi4s_if  (axi4s_if),
   .arst_n    (arst_n),
   .hit       (beat.hit),
   .last      (beat.last),
   .pkt_done  (pkt_done),
   .clear_evt (clear_evt),
   .pkt_bytes (pkt_bytes),
   .pkt_cnt   (pkt_cnt),
   .byte_cnt  (byte_cnt)
);

`default_nettype wire

// File: test/probe_tb.sv
// probe_tb testbench with stimulus tasks, reference counts, compare tasks and timeout
`default_nettype none

module probe_tb;
   import probe_pkg::*;

   localparam int max_len     = 8;   // beats per packet at most
   localparam int idle_cycles = 6;
   localparam int pkt_budget  = 30;  // packets over all tests, rounded up
   localparam int reg_budget  = 80;  // register cycles over all tests
   localparam int timeout_cycles = 8 * (pkt_budget * (max_len + idle_cycles) + reg_budget);

   logic        axi4s_if;
   logic        arst_n;
   logic        tvalid;
   logic        tready;
   logic        tlast;
   logic        tuser;
   keep_t       tkeep;
   logic        reg_wr;
   reg_addr_t   reg_addr;
   reg_data_t   reg_wdata;
   reg_data_t   reg_rdata;

   probe_mode_t cur_mode;     // mode the DUT was last given
   pkt_cnt_t    model_pkts;
   byte_cnt_t   model_bytes;
   int unsigned cycle_count = 0;

   axi4s_probe_top dut (
      .axi4s_if  (axi4s_if),
      .arst_n    (arst_n),
      .tvalid    (tvalid),
      .tready    (tready),
      .tlast     (tlast),
      .tuser     (tuser),
      .tkeep     (tkeep),
      .reg_wr    (reg_wr),
      .reg_addr  (reg_addr),
      .reg_wdata (reg_wdata),
      .reg_rdata (reg_rdata)
   );

   always #10 axi4s_if = ~axi4s_if;

   always @(posedge axi4s_if) begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= timeout_cycles) begin
         $display("timeout: run still going after %0d cycles", cycle_count);
         $display("Checks failed");
         $fatal(1, "simulation stopped by timeout");
      end
   end

   // does a beat with this tready qualify under the mode
   function automatic bit beat_counts(input probe_mode_t m, input bit rdy);
      case (m)
         mode_good, mode_errors: return rdy;
         mode_ovfl:              return !rdy;
         default:                return 1'b0;
      endcase
   endfunction

   function automatic bit pkt_kept(input probe_mode_t m, input bit err);
      case (m)
         mode_good:   return !err;
         mode_errors: return err;
         default:     return 1'b1;
      endcase
   endfunction

   task automatic fail_now();
      $display("Checks failed");
      $fatal(1, "stopping at the first error");
   endtask

   task automatic check_pkt(input string name, input pkt_cnt_t exp, input pkt_cnt_t act);
      if (act !== exp) begin
         $display("** Error %s: packets expected %0d actual %0d", name, exp, act);
         fail_now();
      end
   endtask

   task automatic check_byte(input string name, input byte_cnt_t exp, input byte_cnt_t act);
      if (act !== exp) begin
         $display("** Error %s: bytes expected %0d actual %0d", name, exp, act);
         fail_now();
      end
   endtask

   task automatic check_reg(input string name, input reg_data_t exp, input reg_data_t act);
      if (act !== exp) begin
         $display("** Error %s: register expected 0x%0h actual 0x%0h", name, exp, act);
         fail_now();
      end
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(posedge axi4s_if);
         #2;
         tvalid = 1'b0;
         tlast  = 1'b0;
         tuser  = 1'b0;
         reg_wr = 1'b0;
      end
   endtask

   task automatic reg_write(input reg_addr_t a, input reg_data_t d);
      @(posedge axi4s_if);
      #2;
      reg_wr    = 1'b1;
      reg_addr  = a;
      reg_wdata = d;
      @(posedge axi4s_if);
      #2;
      reg_wr = 1'b0;
   endtask

   task automatic reg_read(input reg_addr_t a, output reg_data_t d);
      @(posedge axi4s_if);
      #2;
      reg_addr = a;
      #1 d = reg_rdata;  // combinational read path
   endtask

   task automatic set_control(input probe_mode_t m, input bit clr, input bit lat);
      reg_data_t w;
      w = '0;
      w[ctrl_mode_lsb +: mode_w] = m;
      w[ctrl_latch_bit]          = lat;
      w[ctrl_clear_bit]          = clr;
      reg_write(addr_control, w);
      cur_mode = m;
      if (clr) begin
         model_pkts  = '0;
         model_bytes = '0;
      end
      idle(2);
   endtask

   // one packet with constant tready, model follows the mode rules
   task automatic send_pkt(input int len, input bit err, input bit rdy);
      keep_t      k;
      pkt_bytes_t sum;
      bit         hit;
      int         b;
      sum = '0;
      hit = beat_counts(cur_mode, rdy);
      for (b = 0; b < len; b++) begin
         k = keep_t'($urandom);
         @(posedge axi4s_if);
         #2;
         tvalid = 1'b1;
         tready = rdy;
         tkeep  = k;
         tlast  = (b == len - 1);
         tuser  = err;
         if (hit) sum = sum + pkt_bytes_t'($countones(k));
      end
      if (hit && pkt_kept(cur_mode, err)) begin
         model_pkts  = model_pkts + pkt_cnt_t'(1);
         model_bytes = model_bytes + byte_cnt_t'(sum);
      end
      idle(idle_cycles);
   endtask

   task automatic send_random(input int n, input bit err, input bit rdy);
      repeat (n) send_pkt(1 + int'($urandom % max_len), err, rdy);
   endtask

   task automatic check_counts(input string name, input pkt_cnt_t ep, input byte_cnt_t eb);
      reg_data_t lo;
      reg_data_t hi;
      reg_read(addr_pkt_lo, lo);
      reg_read(addr_pkt_hi, hi);
      check_reg({name, " pkt_hi"}, reg_data_t'(ep >> reg_data_w), hi);
      check_pkt(name, ep, {hi[pkt_cnt_w-reg_data_w-1:0], lo});
      reg_read(addr_byte_lo, lo);
      reg_read(addr_byte_hi, hi);
      check_reg({name, " byte_hi"}, reg_data_t'(eb >> reg_data_w), hi);
      check_byte(name, eb, {hi[byte_cnt_w-reg_data_w-1:0], lo});
   endtask

   task automatic test_good();
      reg_data_t d;
      send_random(5, 1'b0, 1'b1);
      send_random(1, 1'b1, 1'b1);  // flagged packet, must be skipped
      check_counts("good_mode", model_pkts, model_bytes);
      reg_read(reg_addr_t'(5), d);
      check_reg("unused_addr", '0, d);
   endtask

   task automatic test_errors();
      set_control(mode_errors, 1'b1, 1'b0);
      send_random(2, 1'b0, 1'b1);
      send_random(3, 1'b1, 1'b1);
      check_counts("errors_mode", model_pkts, model_bytes);
   endtask

   task automatic test_ovfl_off();
      set_control(mode_ovfl, 1'b1, 1'b0);
      send_random(2, 1'b0, 1'b0);
      send_random(1, 1'b1, 1'b0);
      send_random(2, 1'b0, 1'b1);  // accepted beats, not overflow
      check_counts("ovfl_mode", model_pkts, model_bytes);
      set_control(mode_off, 1'b0, 1'b0);
      send_random(2, 1'b0, 1'b1);
      send_random(1, 1'b0, 1'b0);
      check_counts("off_mode", model_pkts, model_bytes);
   endtask

   task automatic test_clear();
      set_control(mode_good, 1'b1, 1'b0);
      check_counts("clear_zero", '0, '0);
      send_random(1, 1'b0, 1'b1);
      check_counts("clear_restart", model_pkts, model_bytes);
   endtask

   task automatic test_latch();
      pkt_cnt_t  held_pkts;
      byte_cnt_t held_bytes;
      reg_data_t d;
      set_control(mode_good, 1'b0, 1'b1);
      held_pkts  = model_pkts;
      held_bytes = model_bytes;
      reg_read(addr_control, d);
      check_reg("latch_ctrl", reg_data_t'(32'h2), d);
      send_random(3, 1'b0, 1'b1);
      check_counts("latch_hold", held_pkts, held_bytes);
      set_control(mode_good, 1'b0, 1'b1);  // second write refreshes snapshot
      check_counts("latch_update", model_pkts, model_bytes);
      set_control(mode_good, 1'b0, 1'b0);
   endtask

   initial begin
      void'($urandom(32'h685));
      axi4s_if    = 1'b0;
      arst_n      = 1'b0;
      tvalid      = 1'b0;
      tready      = 1'b1;
      tlast       = 1'b0;
      tuser       = 1'b0;
      tkeep       = '0;
      reg_wr      = 1'b0;
      reg_addr    = '0;
      reg_wdata   = '0;
      cur_mode    = mode_good;
      model_pkts  = '0;
      model_bytes = '0;
      repeat (4) @(posedge axi4s_if);
      #2 arst_n = 1'b1;
      idle(2);
      test_good();
      test_errors();
      test_ovfl_off();
      test_clear();
      test_latch();
      $display("All checks passed");
      $finish;
   end

endmodule

`default_nettype wire

// File: sim.f
verilog/probe_pkg.sv
verilog/beat_if.sv
verilog/beat_capture.sv
verilog/byte_tally.sv
verilog/probe_counters.sv
verilog/probe_regs.sv
verilog/axi4s_probe_top.sv
test/probe_tb_sva.sv
test/probe_tb.sv

// File: Makefile
# Verilator build and run for the AXI4-Stream probe testbench

VERILATOR ?= verilator
TOP       ?= probe_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= All checks passed

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
